// File: Makefile
VERILATOR := verilator
TOP       := ipod_tb
FILELIST  := filelist.f
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
SIM_ARGS  := +verilator+error+limit+1000

OBJ_DIR := obj_dir
SIM_BIN := $(OBJ_DIR)/V$(TOP)
LOG     := sim.log

# Sources from the file list, include directory lines skipped
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
logic/ipod_types_pkg.sv
logic/ipod_timing_pkg.sv
logic/speed_control.sv
logic/tone_source.sv
logic/scope_display.sv
logic/ipod_top.sv
tests/tb_clock_gen.sv
tests/ipod_asserts.sv
tests/ipod_tb.sv

// File: logic/ipod_timing_pkg.sv
package ipod_timing_pkg;

  // ==============================
  // Tick based intervals
  // ==============================

  // Ticks between steps while a key is held
  localparam int repeat_ms = 100;

  // Ticks between display updates
  localparam int refresh_ms = 500;

  // Counter widths for the two pacers
  localparam int repeat_cnt_w = $clog2(repeat_ms);
  localparam int refresh_cnt_w = $clog2(refresh_ms);

  // ==============================
  // Speed control
  // ==============================

  // Change of the offset per step
  localparam int speed_step = 100;

  // Offset magnitude limit
  localparam int max_offset = 12000;

  // Base count of the sampling divider, 4 kHz strobe at 50 MHz
  localparam int default_period = 12499;

  // ==============================
  // Test tone levels
  // ==============================

  // Full positive swing
  localparam ipod_types_pkg::audio_sample_t tone_high = 8'sh7F;

  // Full negative swing
  localparam ipod_types_pkg::audio_sample_t tone_low = 8'sh80;

endpackage

// File: logic/ipod_top.sv
module ipod_top #(
  parameter int clk_per_ms = 50000
) (
  input  logic                          CLK_50M,
  input  logic                          rst,
  input  logic [2:0]                    key,
  input  logic                          scope_enable,
  output ipod_types_pkg::audio_sample_t audio_sample,
  output ipod_types_pkg::scope_bits_t   scope_bits,
  output ipod_types_pkg::seg7_t         hex0,
  output ipod_types_pkg::seg7_t         hex1,
  output ipod_types_pkg::seg7_t         hex2,
  output ipod_types_pkg::seg7_t         hex3,
  output ipod_types_pkg::seg7_t         hex4,
  output ipod_types_pkg::seg7_t         hex5
);
  import ipod_types_pkg::*;

  // Shared millisecond tick
  logic ms_tick;

  // Speed offset from the keys
  speed_offset_t offset;

  // ==============================
  // Tone source
  // ==============================

  tone_source #(
    .clk_per_ms (clk_per_ms)
  ) i_tone_source (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .ms_tick      (ms_tick),
    .audio_sample (audio_sample)
  );

  // ==============================
  // Speed control
  // ==============================

  speed_control i_speed_control (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .key     (key),
    .ms_tick (ms_tick),
    .offset  (offset)
  );

  // Scope and digits combine both parts
  scope_display i_scope_display (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .ms_tick      (ms_tick),
    .offset       (offset),
    .audio_sample (audio_sample),
    .scope_enable (scope_enable),
    .scope_bits   (scope_bits),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex2         (hex2),
    .hex3         (hex3),
    .hex4         (hex4),
    .hex5         (hex5)
  );

endmodule

// File: logic/ipod_types_pkg.sv
package ipod_types_pkg;

  // ==============================
  // Field widths
  // ==============================

  // Audio sample width, two's complement
  localparam int sample_w = 8;

  // Signed offset applied to the sampling count
  localparam int offset_w = 16;

  // Six hex digits on the board
  localparam int digit_cnt = 6;

  // One nibble per digit
  localparam int period_w = 4 * digit_cnt;

  // Scope capture depth
  localparam int capture_w = 16;

  // Segments a to g, no decimal point
  localparam int seg_w = 7;

  // ==============================
  // Types
  // ==============================

  // Test tone sample
  typedef logic signed [sample_w-1:0] audio_sample_t;

  // Speed offset from the keys
  typedef logic signed [offset_w-1:0] speed_offset_t;

  // Sampling period in clock cycles, zero extended to all digits
  typedef logic [period_w-1:0] scope_period_t;

  // Scope shift register contents
  typedef logic [capture_w-1:0] scope_bits_t;

  // One digit, active low, bit 0 is segment a
  typedef logic [seg_w-1:0] seg7_t;

endpackage

// File: logic/scope_display.sv
module scope_display (
  input  logic                          CLK_50M,
  input  logic                          rst,
  input  logic                          ms_tick,
  input  ipod_types_pkg::speed_offset_t offset,
  input  ipod_types_pkg::audio_sample_t audio_sample,
  input  logic                          scope_enable,
  output ipod_types_pkg::scope_bits_t   scope_bits,
  output ipod_types_pkg::seg7_t         hex0,
  output ipod_types_pkg::seg7_t         hex1,
  output ipod_types_pkg::seg7_t         hex2,
  output ipod_types_pkg::seg7_t         hex3,
  output ipod_types_pkg::seg7_t         hex4,
  output ipod_types_pkg::seg7_t         hex5
);
  import ipod_types_pkg::*;
  import ipod_timing_pkg::*;

  localparam logic [refresh_cnt_w-1:0] refresh_last = refresh_cnt_w'(refresh_ms - 1);

  scope_period_t period;
  scope_period_t div_cnt;
  scope_period_t disp_period;
  logic strobe;

  logic en_meta;
  logic en_sync;

  logic [refresh_cnt_w-1:0] refresh_cnt;
  logic refresh_due;

  // Hex digit to segments, order g f e d c b a
  function automatic seg7_t seg7_decode(input logic [3:0] nibble);
    seg7_t seg;
    case (nibble)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0010000;
      4'hA: seg = 7'b0001000;
      4'hB: seg = 7'b0000011;
      4'hC: seg = 7'b1000110;
      4'hD: seg = 7'b0100001;
      4'hE: seg = 7'b0000110;
      default: seg = 7'b0001110;
    endcase
    return seg;
  endfunction

  // ==============================
  // Sampling period and divider
  // ==============================

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      period <= scope_period_t'(default_period);
    else
      period <= scope_period_t'(default_period + int'(offset));
  end

  // Greater or equal, so a shrinking period cannot overrun the count
  assign strobe = (div_cnt >= period);

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      div_cnt <= '0;
    else if (strobe)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  // ==============================
  // Capture register
  // ==============================

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      en_meta <= 1'b0;
      en_sync <= 1'b0;
    end
    else
    begin
      en_meta <= scope_enable;
      en_sync <= en_meta;
    end
  end

  // Inverted sign bit is the tone level
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      scope_bits <= '0;
    else if (strobe && en_sync)
      scope_bits <= {scope_bits[$high(scope_bits)-1:0], ~audio_sample[$high(audio_sample)]};
  end

  // ==============================
  // Display refresh
  // ==============================

  assign refresh_due = ms_tick && (refresh_cnt == refresh_last);

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      refresh_cnt <= '0;
    else if (ms_tick)
    begin
      if (refresh_cnt == refresh_last)
        refresh_cnt <= '0;
      else
        refresh_cnt <= refresh_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      disp_period <= '0;
    else if (refresh_due)
      disp_period <= period;
  end

  assign hex0 = seg7_decode(disp_period[3:0]);
  assign hex1 = seg7_decode(disp_period[7:4]);
  assign hex2 = seg7_decode(disp_period[11:8]);
  assign hex3 = seg7_decode(disp_period[15:12]);
  assign hex4 = seg7_decode(disp_period[19:16]);
  assign hex5 = seg7_decode(disp_period[23:20]);

endmodule

// File: logic/speed_control.sv
module speed_control (
  input  logic                          CLK_50M,
  input  logic                          rst,
  input  logic [2:0]                    key,
  input  logic                          ms_tick,
  output ipod_types_pkg::speed_offset_t offset
);
  import ipod_types_pkg::*;
  import ipod_timing_pkg::*;

  localparam logic [repeat_cnt_w-1:0] repeat_last = repeat_cnt_w'(repeat_ms - 1);

  // Keys after inversion, bit 0 up, bit 1 down, bit 2 clear
  logic [2:0] key_meta;
  logic [2:0] key_sync;

  logic up_held;
  logic down_held;
  logic clear_held;

  logic [repeat_cnt_w-1:0] pace_cnt;
  logic step_due;

  speed_offset_t offset_up;
  speed_offset_t offset_down;
  logic up_ok;
  logic down_ok;

  // ==============================
  // Key synchronizers
  // ==============================

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= ~key;
      key_sync <= key_meta;
    end
  end

  assign up_held    = key_sync[0];
  assign down_held  = key_sync[1];
  assign clear_held = key_sync[2];

  // ==============================
  // Repeat pacer
  // ==============================

  // Free running, so a held key steps once per repeat period
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      pace_cnt <= '0;
    else if (ms_tick)
    begin
      if (pace_cnt == repeat_last)
        pace_cnt <= '0;
      else
        pace_cnt <= pace_cnt + 1'b1;
    end
  end

  assign step_due = ms_tick && (pace_cnt == repeat_last);

  // ==============================
  // Offset register
  // ==============================

  assign offset_up   = offset + speed_offset_t'(speed_step);
  assign offset_down = offset - speed_offset_t'(speed_step);

  // Skip a step that would leave the allowed range
  assign up_ok   = (int'(offset_up) <= max_offset);
  assign down_ok = (int'(offset_down) >= -max_offset);

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      offset <= '0;
    else if (clear_held)
      offset <= '0;
    else if (step_due && up_held && !down_held && up_ok)
      offset <= offset_up;
    else if (step_due && down_held && !up_held && down_ok)
      offset <= offset_down;
  end

endmodule

// File: logic/tone_source.sv
module tone_source #(
  parameter int clk_per_ms = 50000
) (
  input  logic                          CLK_50M,
  input  logic                          rst,
  output logic                          ms_tick,
  output ipod_types_pkg::audio_sample_t audio_sample
);
  import ipod_timing_pkg::*;

  // At least one bit, even for a divide by one
  localparam int cnt_w = (clk_per_ms > 1) ? $clog2(clk_per_ms) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clk_per_ms - 1);

  logic [cnt_w-1:0] ms_cnt;
  logic tone_level;

  // ==============================
  // Millisecond tick
  // ==============================

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      ms_cnt  <= '0;
      ms_tick <= 1'b0;
    end
    else
    begin
      ms_tick <= (ms_cnt == cnt_last);
      if (ms_cnt == cnt_last)
        ms_cnt <= '0;
      else
        ms_cnt <= ms_cnt + 1'b1;
    end
  end

  // Square wave, half period of one tick
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      tone_level <= 1'b0;
    else if (ms_tick)
      tone_level <= ~tone_level;
  end

  assign audio_sample = tone_level ? tone_high : tone_low;

endmodule

// File: tests/ipod_asserts.sv
module ipod_asserts (
  input logic                          CLK_50M,
  input logic                          rst,
  input logic                          scope_enable,
  input ipod_types_pkg::audio_sample_t audio_sample,
  input ipod_types_pkg::speed_offset_t offset,
  input ipod_types_pkg::scope_bits_t   scope_bits
);
  timeunit 1ns;
  timeprecision 100ps;

  import ipod_types_pkg::*;
  import ipod_timing_pkg::*;

  // Failed properties so far
  int fail_count = 0;

  // ==============================
  // Properties
  // ==============================

  // Only the two tone levels
  tone_levels: assert property (@(posedge CLK_50M) disable iff (rst)
    (audio_sample == tone_low) || (audio_sample == tone_high))
  else
  begin
    $error("audio_sample %02h is not a tone level", audio_sample);
    fail_count++;
  end

  // Saturation of the speed offset
  offset_range: assert property (@(posedge CLK_50M) disable iff (rst)
    (int'(offset) <= max_offset) && (int'(offset) >= -max_offset))
  else
  begin
    $error("offset %04h is beyond the allowed magnitude", offset);
    fail_count++;
  end

  // Three cycles cover the enable synchronizer and the shift
  scope_hold: assert property (@(posedge CLK_50M) disable iff (rst)
    (!scope_enable && !$past(scope_enable) && !$past(scope_enable, 2)
      && !$past(scope_enable, 3)) |-> $stable(scope_bits))
  else
  begin
    $error("scope_bits changed to %04h while the scope was disabled", scope_bits);
    fail_count++;
  end

endmodule

bind ipod_top ipod_asserts i_asserts (
  .CLK_50M      (CLK_50M),
  .rst          (rst),
  .scope_enable (scope_enable),
  .audio_sample (audio_sample),
  .offset       (offset),
  .scope_bits   (scope_bits)
);

// File: tests/ipod_tb.sv
module ipod_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import ipod_types_pkg::*;
  import ipod_timing_pkg::*;

  localparam int clk_per_ms = 50;
  localparam int repeat_cycles = repeat_ms * clk_per_ms;
  localparam int settle_cycles = 2 * refresh_ms * clk_per_ms;
  localparam int scope_periods = 20;

  // Keys are active low, bit 0 up, bit 1 down, bit 2 clear
  localparam logic [2:0] key_none  = 3'b111;
  localparam logic [2:0] key_up    = 3'b110;
  localparam logic [2:0] key_down  = 3'b101;
  localparam logic [2:0] key_both  = 3'b100;
  localparam logic [2:0] key_clear = 3'b011;

  // ==============================
  // Stimulus table
  // ==============================

  localparam int row_cnt = 8;
  localparam logic [2:0] row_keys [row_cnt] = '{key_up, key_down, key_clear, key_down,
                                                 key_clear, key_up, key_both, key_clear};
  // Hold length in repeat periods
  localparam int row_periods [row_cnt] = '{3, 5, 1, 122, 1, 2, 4, 1};
  // Period on the digits once the row has settled
  localparam int row_expect [row_cnt] = '{'h31FF, 'h300B, 'h30D3, 'h01F3,
                                          'h30D3, 'h319B, 'h319B, 'h30D3};

  logic CLK_50M;
  logic rst;
  logic [2:0] key;
  logic scope_enable;
  audio_sample_t audio_sample;
  scope_bits_t scope_bits;
  seg7_t hex_digits [6];

  int cycle_count = 0;
  int timeout_cycles;
  int error_count = 0;
  int test_count = 0;
  int failed_tests = 0;
  int model_offset = 0;

  tb_clock_gen i_clock_gen (
    .CLK_50M (CLK_50M),
    .rst     (rst)
  );

  ipod_top #(
    .clk_per_ms (clk_per_ms)
  ) i_dut (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .key          (key),
    .scope_enable (scope_enable),
    .audio_sample (audio_sample),
    .scope_bits   (scope_bits),
    .hex0         (hex_digits[0]),
    .hex1         (hex_digits[1]),
    .hex2         (hex_digits[2]),
    .hex3         (hex_digits[3]),
    .hex4         (hex_digits[4]),
    .hex5         (hex_digits[5])
  );

  // ==============================
  // Helpers
  // ==============================

  task automatic next_cycle();
    @(posedge CLK_50M);
    #2;
  endtask

  function automatic string key_name(input logic [2:0] keys);
    case (keys)
      key_up: return "up";
      key_down: return "down";
      key_both: return "up and down";
      default: return "clear";
    endcase
  endfunction

  // Lit segments, order g f e d c b a
  function automatic int segments_to_nibble(input seg7_t seg);
    case (~seg)
      7'h3F: return 0;
      7'h06: return 1;
      7'h5B: return 2;
      7'h4F: return 3;
      7'h66: return 4;
      7'h6D: return 5;
      7'h7D: return 6;
      7'h07: return 7;
      7'h7F: return 8;
      7'h6F: return 9;
      7'h77: return 10;
      7'h7C: return 11;
      7'h39: return 12;
      7'h5E: return 13;
      7'h79: return 14;
      7'h71: return 15;
      default: return -1;
    endcase
  endfunction

  function automatic int planned_cycles();
    int total;
    total = settle_cycles + 10 * clk_per_ms;
    for (int r = 0; r < row_cnt; r++)
      total += row_periods[r] * repeat_cycles + settle_cycles;
    total += (scope_periods + 3) * (row_expect[row_cnt-1] + 1) + 4;
    return total;
  endfunction

  // Offset model, one step per repeat period with saturation
  task automatic step_model(input logic [2:0] keys, input int periods);
    for (int i = 0; i < periods; i++)
    begin
      if (keys == key_clear)
        model_offset = 0;
      else if (keys == key_up && model_offset + speed_step <= max_offset)
        model_offset += speed_step;
      else if (keys == key_down && model_offset - speed_step >= -max_offset)
        model_offset -= speed_step;
    end
  endtask

  task automatic check_display(input int expected);
    int shown;
    int nibble;
    bit valid;
    shown = 0;
    valid = 1'b1;
    for (int d = 5; d >= 0; d--)
    begin
      nibble = segments_to_nibble(hex_digits[d]);
      if (nibble < 0)
      begin
        $display("error hex%0d: segments %02h are no hex digit", d, hex_digits[d]);
        valid = 1'b0;
      end
      shown = (shown << 4) | (nibble & 'hF);
    end
    if (!valid)
      error_count++;
    else if (shown != expected)
    begin
      $display("error hex5..hex0: expected %06h, got %06h", expected, shown);
      error_count++;
    end
  endtask

  // Each level lasts one tick, then the other level follows
  task automatic check_tone();
    audio_sample_t level;
    int run_len;
    level = audio_sample;
    while (audio_sample == level)
      next_cycle();
    for (int r = 0; r < 4; r++)
    begin
      level = audio_sample;
      run_len = 0;
      while (audio_sample == level)
      begin
        next_cycle();
        run_len++;
      end
      if (run_len != clk_per_ms)
      begin
        $display("error audio_sample run length: expected %0h, got %0h", clk_per_ms, run_len);
        error_count++;
      end
      if (audio_sample != ((level == tone_low) ? tone_high : tone_low))
      begin
        $display("error audio_sample: got %02h after %02h", audio_sample, level);
        error_count++;
      end
    end
  endtask

  task automatic check_scope(input int sample_cycles);
    scope_bits_t held;
    scope_enable = 1'b1;
    repeat (scope_periods * sample_cycles)
      next_cycle();
    scope_enable = 1'b0;
    // Enable synchronizer drains
    repeat (4)
      next_cycle();
    held = scope_bits;
    if (held != '0 && held != '1)
    begin
      $display("error scope_bits: expected 0000 or ffff, got %04h", held);
      error_count++;
    end
    repeat (3 * sample_cycles)
      next_cycle();
    if (scope_bits != held)
    begin
      $display("error scope_bits: expected %04h, got %04h", held, scope_bits);
      error_count++;
    end
  endtask

  task automatic finish_test(input string label, input int errors_at_start);
    test_count++;
    if (error_count == errors_at_start)
      $display("test %0d %s: ok", test_count, label);
    else
    begin
      failed_tests++;
      $display("test %0d %s: failed", test_count, label);
    end
  endtask

  // ==============================
  // Timeout
  // ==============================

  always @(posedge CLK_50M)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles)
    begin
      $display("timeout after %0d cycles, a test did not finish", cycle_count);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // ==============================
  // Test sequence
  // ==============================

  initial
  begin
    int errors_at_start;
    key = key_none;
    scope_enable = 1'b0;
    timeout_cycles = planned_cycles() * 3 / 2;
    wait (rst == 1'b0);

    errors_at_start = error_count;
    if (audio_sample != tone_low)
    begin
      $display("error audio_sample: expected %02h, got %02h", tone_low, audio_sample);
      error_count++;
    end
    repeat (settle_cycles)
      next_cycle();
    check_display(default_period);
    finish_test("reset state", errors_at_start);

    errors_at_start = error_count;
    check_tone();
    finish_test("tone levels and timing", errors_at_start);

    for (int r = 0; r < row_cnt; r++)
    begin
      errors_at_start = error_count;
      step_model(row_keys[r], row_periods[r]);
      if (default_period + model_offset != row_expect[r])
      begin
        $display("table row %0d does not agree with the offset model", r);
        error_count++;
      end
      key = row_keys[r];
      repeat (row_periods[r] * repeat_cycles)
        next_cycle();
      key = key_none;
      repeat (settle_cycles)
        next_cycle();
      check_display(row_expect[r]);
      finish_test($sformatf("%s for %0d repeat periods", key_name(row_keys[r]),
                            row_periods[r]), errors_at_start);
    end

    // Period plus one is a whole number of tone periods here
    errors_at_start = error_count;
    check_scope(row_expect[row_cnt-1] + 1);
    finish_test("scope capture and hold", errors_at_start);

    $display("tests %0d, passed %0d, failed %0d, assertion failures %0d", test_count,
             test_count - failed_tests, failed_tests, i_dut.i_asserts.fail_count);
    if (failed_tests == 0 && i_dut.i_asserts.fail_count == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: tests/tb_clock_gen.sv
module tb_clock_gen (
  output logic CLK_50M,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int reset_cycles = 8;

  // 20 ns period
  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // Released just after an edge, like the other inputs
  initial
  begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge CLK_50M);
    #2 rst = 1'b0;
  end

endmodule
